//--- bench/mxu_checker.sv
`timescale 1ns/10ps

module mxu_checker (
   input logic clk,
   input logic reset,
   input logic enable,
   input logic load,
   input logic in_valid,
   input logic out_valid
);

   logic [mxu_pkg::latency-1:0] flight;  // valid bits still inside the pipeline
   int since_reset;                      // enabled edges since reset, saturates

   ////////////////////
   // shadow state

   always_ff @(posedge clk) begin
      if (reset) begin
         flight <= '0;
         since_reset <= 0;
      end else if (enable) begin
         flight <= {flight[mxu_pkg::latency-2:0], in_valid};
         if (since_reset < mxu_pkg::latency) begin
            since_reset <= since_reset + 1;
         end
      end
   end

   ////////////////////
   // properties

   a_quiet_after_reset : assert property (@(posedge clk) disable iff (reset)
      (since_reset < mxu_pkg::latency) |-> !out_valid)
      else $error("out_valid high before the first result can exist");

   // weights change under no vector
   a_load_when_empty : assert property (@(posedge clk) disable iff (reset)
      (load && enable) |-> (flight == '0))
      else $error("load while vectors are in flight");

   a_hold_while_stalled : assert property (@(posedge clk) disable iff (reset)
      !enable |=> $stable(out_valid))
      else $error("out_valid moved while enable was low");

endmodule

//--- bench/mxu_tb.sv
`timescale 1ns/10ps

module mxu_tb;

   localparam int n_tests = 6;

   typedef struct packed {
      mxu_pkg::precision_t  dt;
      mxu_pkg::weight_vec_t w;
      int                   count;      // input vectors
      logic                 gaps;       // random enable low cycles
      logic                 sparse;     // random in_valid low
      logic                 rand_data;  // else fixed extremes
   } test_row_t;

   typedef logic [mxu_pkg::acc_lane_w-1:0] lane_acc_t;

   logic clk;
   logic reset;
   logic enable;
   logic load;
   logic in_valid;
   mxu_pkg::weight_vec_t weight;
   mxu_pkg::precision_t  data_type;
   mxu_pkg::data_vec_t   in_data;
   mxu_pkg::acc_vec_t    y;
   logic                 out_valid;

   // weights packed as {row 2, row 1, row 0}
   test_row_t tests [n_tests] = '{
      '{mxu_pkg::prec_int8,   24'h03807f, 12, 1'b0, 1'b0, 1'b0},
      '{mxu_pkg::prec_int8,   24'hc57f80, 20, 1'b0, 1'b0, 1'b1},
      '{mxu_pkg::prec_int4x2, 24'h887887, 12, 1'b0, 1'b0, 1'b0},
      '{mxu_pkg::prec_int4x2, 24'h5af17f, 20, 1'b1, 1'b0, 1'b1},
      '{mxu_pkg::prec_int8,   24'h40ff01, 24, 1'b1, 1'b1, 1'b1},
      '{mxu_pkg::prec_int4x2, 24'h77813c, 16, 1'b0, 1'b1, 1'b1}
   };

   integer seed = 32'h9499_71be;
   int errors = 0;
   int pass_count = 0;
   int fail_count = 0;
   int en_edges = 0;   // enabled edges out of reset
   int cycles;
   int limit;
   int checked;
   int sent;
   mxu_pkg::precision_t  cur_dt;
   mxu_pkg::weight_vec_t cur_w;
   mxu_pkg::acc_vec_t    exp_q [$];  // expected results in order
   int                   edge_q [$];  // en_edges before each accepting edge

   mxu_top dut0 (
      .clk       (clk),
      .reset     (reset),
      .enable    (enable),
      .load      (load),
      .weight    (weight),
      .data_type (data_type),
      .in_valid  (in_valid),
      .in_data   (in_data),
      .y         (y),
      .out_valid (out_valid)
   );

   bind mxu_top mxu_checker checker0 (
      .clk       (clk),
      .reset     (reset),
      .enable    (enable),
      .load      (load),
      .in_valid  (in_valid),
      .out_valid (out_valid)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      if (!reset && enable) begin
         en_edges <= en_edges + 1;
      end
   end

   ////////////////////
   // reference model

   // row i gets w_i times the column sum, per lane in dual mode
   function automatic mxu_pkg::acc_vec_t model_result(input mxu_pkg::precision_t dt,
                                                       input mxu_pkg::weight_vec_t w,
                                                       input mxu_pkg::data_vec_t v);
      mxu_pkg::acc_vec_t res;
      mxu_pkg::data_t e;
      mxu_pkg::data_t we;
      int sum_v;
      int sum_lo;
      int sum_hi;
      res = '0;
      for (int i = 0; i < mxu_pkg::rows_m; i++) begin
         we = w[i*mxu_pkg::data_w +: mxu_pkg::data_w];
         sum_v = 0;
         sum_lo = 0;
         sum_hi = 0;
         for (int j = 0; j < mxu_pkg::cols_k; j++) begin
            e = v[j*mxu_pkg::data_w +: mxu_pkg::data_w];
            sum_v += int'($signed(e));
            sum_lo += int'($signed(e[mxu_pkg::lane_w-1:0]));
            sum_hi += int'($signed(e[mxu_pkg::data_w-1:mxu_pkg::lane_w]));
         end
         if (dt == mxu_pkg::prec_int8) begin
            res[i*mxu_pkg::acc_w +: mxu_pkg::acc_w] = mxu_pkg::acc_t'(int'($signed(we)) * sum_v);
         end else begin
            res[i*mxu_pkg::acc_w +: mxu_pkg::acc_w] = {
               lane_acc_t'(int'($signed(we[mxu_pkg::data_w-1:mxu_pkg::lane_w])) * sum_hi),
               lane_acc_t'(int'($signed(we[mxu_pkg::lane_w-1:0])) * sum_lo)};
         end
      end
      return res;
   endfunction

   // signed corners for both precisions
   function automatic mxu_pkg::data_t fixed_elem(input int k);
      case (k % 8)
         0: return 8'h80;
         1: return 8'h7f;
         2: return 8'h88;
         3: return 8'h77;
         4: return 8'hff;
         5: return 8'h01;
         6: return 8'h00;
         default: return 8'h78;
      endcase
   endfunction

   function automatic mxu_pkg::data_vec_t fixed_vec(input int n);
      mxu_pkg::data_vec_t v;
      for (int j = 0; j < mxu_pkg::cols_k; j++) begin
         v[j*mxu_pkg::data_w +: mxu_pkg::data_w] = fixed_elem(n*mxu_pkg::cols_k + j);
      end
      return v;
   endfunction

   function automatic int timeout_limit();
      int total;
      total = 2 + mxu_pkg::latency + 10;  // reset and idle check
      for (int t = 0; t < n_tests; t++) begin
         total += tests[t].count * (tests[t].gaps ? 2 : 1) + mxu_pkg::latency + 10;
      end
      return total;
   endfunction

   ////////////////////
   // compare tasks

   task automatic check_acc_vec(input mxu_pkg::acc_vec_t got, input mxu_pkg::acc_vec_t exp,
                                input string what);
      if (got !== exp) begin
         $display("Error at time %0t: %s, y = %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic check_valid(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("Error at time %0t: %s, out_valid = %b, expected %b", $time, what, got, exp);
         errors++;
      end
   endtask

   ////////////////////
   // drive and observe

   // outputs here come from the last rising edge, inputs not yet changed
   task automatic observe_outputs();
      logic exp_v;
      mxu_pkg::acc_vec_t exp_y;
      if (!reset && enable) begin
         exp_v = (edge_q.size() > 0) && (edge_q[0] + mxu_pkg::latency == en_edges);
         check_valid(out_valid, exp_v, $sformatf("valid timing after result %0d", checked));
         if (out_valid) begin
            if (exp_q.size() == 0) begin
               $display("extra result: out_valid high at time %0t with nothing outstanding",
                        $time);
               errors++;
            end else begin
               exp_y = exp_q.pop_front();
               void'(edge_q.pop_front());
               check_acc_vec(y, exp_y, $sformatf("result %0d", checked));
               checked++;
            end
         end
      end
   endtask

   task automatic drive_cycle(input logic en, input logic lod, input logic vld,
                              input mxu_pkg::data_vec_t d);
      @(negedge clk);
      observe_outputs();
      enable = en;
      load = lod;
      in_valid = vld;
      in_data = d;
      if (en && vld) begin
         exp_q.push_back(model_result(cur_dt, cur_w, d));
         edge_q.push_back(en_edges);
         sent++;
      end
   endtask

   task automatic report_test(input string label, input int errs_before);
      $display("test %s: %0d vectors sent, %0d results checked, %0d errors",
               label, sent, checked, errors - errs_before);
      if (errors == errs_before) begin
         pass_count++;
      end else begin
         fail_count++;
      end
   endtask

   // one real vector on the first enabled edge, weights still at reset value
   task automatic check_idle();
      int errs_before;
      errs_before = errors;
      sent = 0;
      checked = 0;
      for (int c = 0; c < mxu_pkg::latency + 2; c++) begin
         drive_cycle(1'b1, 1'b0, c == 0, fixed_vec(c));
         if (c == 0) begin
            check_valid(out_valid, 1'b0, "reset value");
         end
         check_acc_vec(y, '0, "zero weights after reset");
      end
      report_test("reset", errs_before);
   endtask

   task automatic run_test(input int t);
      int errs_before;
      int drain;
      logic [31:0] r;
      logic vld;
      mxu_pkg::data_vec_t d;
      errs_before = errors;
      sent = 0;
      checked = 0;
      cur_dt = tests[t].dt;
      cur_w = tests[t].w;
      weight = cur_w;
      data_type = cur_dt;
      drive_cycle(1'b1, 1'b1, 1'b0, '0);  // load with an empty pipeline
      for (int n = 0; n < tests[t].count; n++) begin
         r = $random(seed);
         if (tests[t].gaps && r[0]) begin
            drive_cycle(1'b0, 1'b0, 1'b0, '0);
         end
         r = $random(seed);
         vld = tests[t].sparse ? (r[1:0] != 2'b00) : 1'b1;
         r = $random(seed);
         d = tests[t].rand_data ? mxu_pkg::data_vec_t'(r) : fixed_vec(n);
         drive_cycle(1'b1, 1'b0, vld, d);
      end
      drain = 0;
      while (exp_q.size() > 0 && drain < mxu_pkg::latency + 2) begin
         drive_cycle(1'b1, 1'b0, 1'b0, '0);
         drain++;
      end
      if (exp_q.size() > 0) begin
         $display("missing results: %0d vectors of test %0d never came out",
                  exp_q.size(), t);
         errors += exp_q.size();
         exp_q.delete();
         edge_q.delete();
      end
      repeat (2) drive_cycle(1'b1, 1'b0, 1'b0, '0);  // flush the last valid bit
      report_test($sformatf("%0d (%s)", t, cur_dt == mxu_pkg::prec_int8 ? "int8" : "int4x2"),
                  errs_before);
   endtask

   ////////////////////
   // run

   initial begin
      cycles = 0;
      limit = timeout_limit();
      while (cycles < limit) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: no verdict after %0d clock cycles", limit);
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      reset = 1'b1;
      enable = 1'b0;
      load = 1'b0;
      in_valid = 1'b0;
      in_data = '0;
      weight = '0;
      data_type = mxu_pkg::prec_int8;
      cur_dt = mxu_pkg::prec_int8;
      cur_w = '0;
      repeat (2) @(negedge clk);
      reset = 1'b0;
      check_idle();
      for (int t = 0; t < n_tests; t++) begin
         run_test(t);
      end
      $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

//--- design/mxu_control.sv
`timescale 1ns/10ps

module mxu_control (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 enable,
   input  logic                 load,
   input  logic                 in_valid,
   input  mxu_pkg::weight_vec_t weight,
   input  mxu_pkg::precision_t  data_type,
   output mxu_pkg::weight_vec_t weight_q,
   output mxu_pkg::precision_t  data_type_q,
   output logic                 out_valid
);

   logic [mxu_pkg::latency-1:0] valid_sr;  // one bit per vector in flight

   ////////////////////
   // weight and precision

   // held until the next load, shared by the whole grid
   always_ff @(posedge clk) begin
      if (reset) begin
         weight_q <= '0;
         data_type_q <= mxu_pkg::prec_int8;
      end else if (enable && load) begin
         weight_q <= weight;
         data_type_q <= data_type;
      end
   end

   ////////////////////
   // valid pipeline

   // tracks the data path edge for edge, stalls with it
   always_ff @(posedge clk) begin
      if (reset) begin
         valid_sr <= '0;
      end else if (enable) begin
         valid_sr <= {valid_sr[mxu_pkg::latency-2:0], in_valid};
      end
   end

   assign out_valid = valid_sr[mxu_pkg::latency-1];  // lines up with y

endmodule

//--- design/mxu_core.sv
`timescale 1ns/10ps

module mxu_core (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 enable,
   input  mxu_pkg::precision_t  data_type,
   input  mxu_pkg::data_vec_t   input_data,
   input  mxu_pkg::weight_vec_t weight,
   output mxu_pkg::acc_vec_t    y
);

   // psum[i][j] enters cell (i,j), psum[i][cols_k] is the row result
   mxu_pkg::acc_t psum [mxu_pkg::rows_m][mxu_pkg::cols_k+1];
   // fwd[i][j] is the element seen by row i in column j
   mxu_pkg::data_t fwd [mxu_pkg::rows_m+1][mxu_pkg::cols_k];

   ////////////////////
   // grid edges

   genvar i, j;

   generate
      for (j = 0; j < mxu_pkg::cols_k; j = j + 1) begin : g_top_edge
         assign fwd[0][j] = input_data[j*mxu_pkg::data_w +: mxu_pkg::data_w];  // row 0 feed
      end

      for (i = 0; i < mxu_pkg::rows_m; i = i + 1) begin : g_side_edge
         assign psum[i][0] = '0;  // each row starts from zero
         assign y[i*mxu_pkg::acc_w +: mxu_pkg::acc_w] = psum[i][mxu_pkg::cols_k];
      end
   endgenerate

   ////////////////////
   // cell array

   // sums step right one column per cycle, data steps down one row,
   // so a partial sum always meets the element from its own vector
   generate
      for (i = 0; i < mxu_pkg::rows_m; i = i + 1) begin : rows
         for (j = 0; j < mxu_pkg::cols_k; j = j + 1) begin : columns
            mxu_mac mac_i_j (
               .clk                 (clk),
               .reset               (reset),
               .enable              (enable),
               .data_type           (data_type),
               .data_input          (fwd[i][j]),
               .weight              (weight[i*mxu_pkg::data_w +: mxu_pkg::data_w]),
               .res_mac_p           (psum[i][j]),
               .res_mac_n           (psum[i][j+1]),
               .data_input_next_row (fwd[i+1][j])  // bottom row output unused
            );
         end
      end
   endgenerate

endmodule

//--- design/mxu_mac.sv
`timescale 1ns/10ps

module mxu_mac (
   input  logic                clk,
   input  logic                reset,
   input  logic                enable,
   input  mxu_pkg::precision_t data_type,
   input  mxu_pkg::data_t      data_input,
   input  mxu_pkg::data_t      weight,
   input  mxu_pkg::acc_t       res_mac_p,
   output mxu_pkg::acc_t       res_mac_n,
   output mxu_pkg::data_t      data_input_next_row
);

   logic signed [2*mxu_pkg::data_w-1:0] prod_full;  // int8 product
   logic signed [2*mxu_pkg::lane_w-1:0] prod_lo;    // low sub-word product
   logic signed [2*mxu_pkg::lane_w-1:0] prod_hi;    // high sub-word product
   logic [mxu_pkg::acc_lane_w-1:0] sum_lo;
   logic [mxu_pkg::acc_lane_w-1:0] sum_hi;
   mxu_pkg::acc_t sum_full;
   mxu_pkg::acc_t sum_next;

   ////////////////////
   // multipliers

   always_comb begin
      prod_full = $signed(data_input) * $signed(weight);
      prod_lo = $signed(data_input[mxu_pkg::lane_w-1:0])
                * $signed(weight[mxu_pkg::lane_w-1:0]);
      prod_hi = $signed(data_input[mxu_pkg::data_w-1:mxu_pkg::lane_w])
                * $signed(weight[mxu_pkg::data_w-1:mxu_pkg::lane_w]);
   end

   ////////////////////
   // accumulate

   always_comb begin
      // full width, product sign extended to acc_w
      sum_full = res_mac_p
                 + {{(mxu_pkg::acc_w-2*mxu_pkg::data_w){prod_full[2*mxu_pkg::data_w-1]}},
                    prod_full};
      // each half wraps on its own so no carry crosses
      sum_lo = res_mac_p[mxu_pkg::acc_lane_w-1:0]
               + {{(mxu_pkg::acc_lane_w-2*mxu_pkg::lane_w){prod_lo[2*mxu_pkg::lane_w-1]}},
                  prod_lo};
      sum_hi = res_mac_p[mxu_pkg::acc_w-1:mxu_pkg::acc_lane_w]
               + {{(mxu_pkg::acc_lane_w-2*mxu_pkg::lane_w){prod_hi[2*mxu_pkg::lane_w-1]}},
                  prod_hi};
      if (data_type == mxu_pkg::prec_int4x2) begin
         sum_next = {sum_hi, sum_lo};
      end else begin
         sum_next = sum_full;
      end
   end

   // partial sum to the right, data one row down
   always_ff @(posedge clk) begin
      if (reset) begin
         res_mac_n <= '0;
         data_input_next_row <= '0;
      end else if (enable) begin
         res_mac_n <= sum_next;
         data_input_next_row <= data_input;
      end
   end

endmodule

//--- design/mxu_pkg.sv
package mxu_pkg;

   ////////////////////
   // array dimensions

   localparam int rows_m = 3;   // weights, one per row
   localparam int cols_k = 3;   // input elements, one per column

   ////////////////////
   // widths

   localparam int data_w = 8;            // element and weight
   localparam int acc_w = 20;            // row accumulator
   localparam int lane_w = 4;            // sub-word in dual mode
   localparam int acc_lane_w = acc_w / 2; // accumulator half per sub-word

   // accepted input to result, counted in enabled edges
   localparam int latency = cols_k + rows_m;

   ////////////////////
   // vector types

   typedef logic [data_w-1:0] data_t;
   typedef logic [acc_w-1:0] acc_t;

   // column j sits in slice j
   typedef logic [cols_k*data_w-1:0] data_vec_t;
   // row i sits in slice i
   typedef logic [rows_m*data_w-1:0] weight_vec_t;
   typedef logic [rows_m*acc_w-1:0] acc_vec_t;

   ////////////////////
   // precision select

   typedef enum logic [0:0] {
      prec_int8   = 1'b0,  // one signed 8 bit value
      prec_int4x2 = 1'b1   // two signed 4 bit lanes
   } precision_t;

endpackage

//--- design/mxu_skew.sv
`timescale 1ns/10ps

module mxu_skew #(
   parameter int lanes      = 3,
   parameter int lane_w     = 8,
   parameter bit descending = 1'b0
) (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    enable,
   input  logic [lanes*lane_w-1:0] din,
   output logic [lanes*lane_w-1:0] dout
);

   genvar k;

   // ascending side: lane k waits k cycles, lane 0 is a plain wire
   // descending side: lane k waits lanes-1-k cycles plus one output
   // register, so every lane of the deskew ends on a flop
   generate
      for (k = 0; k < lanes; k = k + 1) begin : g_lane
         localparam int depth = descending ? (lanes - k) : k;

         if (depth == 0) begin : g_pass
            assign dout[k*lane_w +: lane_w] = din[k*lane_w +: lane_w];
         end else begin : g_chain
            logic [lane_w-1:0] stage [depth];

            always_ff @(posedge clk) begin
               if (reset) begin
                  for (int s = 0; s < depth; s++) begin
                     stage[s] <= '0;
                  end
               end else if (enable) begin
                  stage[0] <= din[k*lane_w +: lane_w];
                  for (int s = 1; s < depth; s++) begin
                     stage[s] <= stage[s-1];  // shift toward the tail
                  end
               end
            end

            assign dout[k*lane_w +: lane_w] = stage[depth-1];
         end
      end
   endgenerate

endmodule

//--- design/mxu_top.sv
`timescale 1ns/10ps

module mxu_top (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 enable,
   input  logic                 load,
   input  mxu_pkg::weight_vec_t weight,
   input  mxu_pkg::precision_t  data_type,
   input  logic                 in_valid,
   input  mxu_pkg::data_vec_t   in_data,
   output mxu_pkg::acc_vec_t    y,
   output logic                 out_valid
);

   mxu_pkg::weight_vec_t weight_q;
   mxu_pkg::precision_t  data_type_q;
   mxu_pkg::data_vec_t   skewed_data;  // column j late by j cycles
   mxu_pkg::acc_vec_t    core_y;       // row i early by rows_m-1-i cycles

   mxu_control control0 (
      .clk         (clk),
      .reset       (reset),
      .enable      (enable),
      .load        (load),
      .in_valid    (in_valid),
      .weight      (weight),
      .data_type   (data_type),
      .weight_q    (weight_q),
      .data_type_q (data_type_q),
      .out_valid   (out_valid)
   );

   ////////////////////
   // data path

   mxu_skew #(
      .lanes      (mxu_pkg::cols_k),
      .lane_w     (mxu_pkg::data_w),
      .descending (1'b0)
   ) in_skew0 (
      .clk    (clk),
      .reset  (reset),
      .enable (enable),
      .din    (in_data),
      .dout   (skewed_data)
   );

   mxu_core core0 (
      .clk        (clk),
      .reset      (reset),
      .enable     (enable),
      .data_type  (data_type_q),
      .input_data (skewed_data),
      .weight     (weight_q),
      .y          (core_y)
   );

   // realigns rows and holds the output register
   mxu_skew #(
      .lanes      (mxu_pkg::rows_m),
      .lane_w     (mxu_pkg::acc_w),
      .descending (1'b1)
   ) out_skew0 (
      .clk    (clk),
      .reset  (reset),
      .enable (enable),
      .din    (core_y),
      .dout   (y)
   );

endmodule

//--- filelist.f
design/mxu_pkg.sv
design/mxu_mac.sv
design/mxu_skew.sv
design/mxu_core.sv
design/mxu_control.sv
design/mxu_top.sv
bench/mxu_checker.sv
bench/mxu_tb.sv

//--- run.sh
#!/bin/sh
# build and run the matrix unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module mxu_tb -o mxu_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

out=$(./obj_dir/mxu_sim)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$out" | grep -q "TEST PASSED"; then
   exit 0
fi
exit 1
